// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_pcie_cont_read
FILELIST  = pcie_cont_read.f
OBJ_DIR   = obj_dir
PASS_MSG  = >>> PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: common/rd_cfg.svh
`ifndef RD_CFG_SVH
`define RD_CFG_SVH

// Scratchpad slots
`define RD_SLOT_COUNT       16
`define RD_SLOT_BITS        4
`define RD_SLOT_SPAN_BITS   11

`define RD_PCIE_ADDR_BITS   64
`define RD_HOST_RAM_BITS    32
`define RD_HOST_TAG_BITS    32
`define RD_LEN_BITS         16
`define RD_CORE_ADDR_BITS   16
`define RD_CORE_DEST_BITS   9
`define RD_CORE_ID_BITS     4
`define RD_CTRL_BITS        128

// Core control word layout
`define RD_CTRL_LEN_LSB       0
`define RD_CTRL_DEST_LSB      16
`define RD_CTRL_CORE_ADDR_LSB 32
`define RD_CTRL_PCIE_ADDR_LSB 64

`endif

// File: common/rd_pkg.sv
`default_nettype none

`include "rd_cfg.svh"

package rd_pkg;

  typedef logic [`RD_PCIE_ADDR_BITS-1:0] pcie_addr_t;
  typedef logic [`RD_HOST_RAM_BITS-1:0]  host_ram_addr_t;
  typedef logic [`RD_HOST_TAG_BITS-1:0]  host_tag_t;
  typedef logic [`RD_LEN_BITS-1:0]       dma_len_t;
  typedef logic [`RD_SLOT_BITS-1:0]      slot_t;

  // Slot number above the byte offset inside a slot
  typedef logic [`RD_SLOT_BITS+`RD_SLOT_SPAN_BITS-1:0] scratch_addr_t;

  typedef logic [`RD_CORE_ADDR_BITS-1:0] core_addr_t;
  typedef logic [`RD_CORE_DEST_BITS-1:0] core_dest_t;
  typedef logic [`RD_CORE_ID_BITS-1:0]   core_id_t;
  typedef logic [`RD_CTRL_BITS-1:0]      ctrl_word_t;

endpackage

`default_nettype wire

// File: common/slot_alloc_if.sv
`timescale 1ns/100ps
`default_nettype none

interface slot_alloc_if import rd_pkg::*; ();

  slot_t      free_slot;
  logic       any_free;

  // One-cycle strobe, entry goes into free_slot
  logic       alloc;
  dma_len_t   entry_len;
  core_addr_t entry_core_addr;
  core_dest_t entry_dest;
  host_tag_t  entry_host_tag;

  modport intake (
    input  free_slot, any_free,
    output alloc, entry_len, entry_core_addr, entry_dest, entry_host_tag
  );

  modport store (
    output free_slot, any_free,
    input  alloc, entry_len, entry_core_addr, entry_dest, entry_host_tag
  );

endinterface

`default_nettype wire

// File: common/slot_lookup_if.sv
`timescale 1ns/100ps
`default_nettype none

interface slot_lookup_if import rd_pkg::*; ();

  // Completion lookup, answered combinationally
  slot_t      lookup_slot;
  dma_len_t   entry_len;
  core_addr_t entry_core_addr;
  core_dest_t entry_dest;
  host_tag_t  entry_host_tag;

  // Slot release, with its own tag read port
  logic       release_valid;
  slot_t      release_slot;
  host_tag_t  release_host_tag;

  modport stage (
    output lookup_slot, release_valid, release_slot,
    input  entry_len, entry_core_addr, entry_dest, entry_host_tag, release_host_tag
  );

  modport store (
    input  lookup_slot, release_valid, release_slot,
    output entry_len, entry_core_addr, entry_dest, entry_host_tag, release_host_tag
  );

endinterface

`default_nettype wire

// File: design/completion_stage.sv
`timescale 1ns/100ps
`default_nettype none

module completion_stage import rd_pkg::*; (
  input  wire          pcie_clk,
  input  wire          pcie_rst,

  input  wire slot_t   pcie_status_slot,
  input  wire          pcie_status_valid,

  input  wire slot_t   readout_status_slot,
  input  wire          readout_status_valid,

  slot_lookup_if.stage lookup,

  output dma_len_t     rd_len,
  output slot_t        rd_slot,
  output core_dest_t   rd_dest,
  output core_addr_t   rd_core_addr,
  output logic         rd_push,

  output host_tag_t    host_status_tag,
  output logic         host_status_valid
);

  logic  release_q;
  slot_t release_slot_q;

  assign lookup.lookup_slot = pcie_status_slot;

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      rd_push   <= 1'b0;
      release_q <= 1'b0;
    end else begin
      rd_push   <= pcie_status_valid;
      release_q <= readout_status_valid;
    end
  end

  // Stored entry becomes the readout descriptor
  always_ff @(posedge pcie_clk) begin
    if (pcie_status_valid) begin
      rd_len       <= lookup.entry_len;
      rd_slot      <= pcie_status_slot;
      rd_dest      <= lookup.entry_dest;
      rd_core_addr <= lookup.entry_core_addr;
    end
    if (readout_status_valid) begin
      release_slot_q <= readout_status_slot;
    end
  end

  assign lookup.release_valid = release_q;
  assign lookup.release_slot  = release_slot_q;

  // Entry is still intact while the release is in flight
  assign host_status_tag   = lookup.release_host_tag;
  assign host_status_valid = release_q && (lookup.release_host_tag != '0);

endmodule

`default_nettype wire

// File: design/desc_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module desc_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 16
) (
  input  wire             pcie_clk,
  input  wire             pcie_rst,

  input  wire [WIDTH-1:0] din,
  input  wire             din_valid,

  output logic [WIDTH-1:0] dout,
  output logic             dout_valid,
  input  wire              dout_ready
);

  localparam int PTR_BITS = $clog2(DEPTH);

  logic [WIDTH-1:0]    mem [DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [PTR_BITS:0]   count;

  logic pop;
  logic out_load;
  logic buf_empty;
  logic buf_rd;
  logic buf_wr;

  assign pop       = dout_valid && dout_ready;
  // Output register can take a word this cycle
  assign out_load  = !dout_valid || pop;
  assign buf_empty = (count == '0);
  assign buf_rd    = out_load && !buf_empty;
  // Bypass into the output register when nothing is buffered
  assign buf_wr    = din_valid && !(out_load && buf_empty);

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      dout_valid <= 1'b0;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
    end else begin
      if (out_load) begin
        dout_valid <= !buf_empty || din_valid;
      end
      if (buf_wr) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (buf_rd) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({buf_wr, buf_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (buf_wr) begin
      mem[wr_ptr] <= din;
    end
    if (out_load) begin
      dout <= buf_empty ? din : mem[rd_ptr];
    end
  end

endmodule

`default_nettype wire

// File: design/pcie_cont_read.sv
`timescale 1ns/100ps
`default_nettype none

`include "rd_cfg.svh"

module pcie_cont_read import rd_pkg::*; (
  input  wire                 pcie_clk,
  input  wire                 pcie_rst,

  // Host read requests
  input  wire pcie_addr_t     host_dma_read_desc_pcie_addr,
  input  wire host_ram_addr_t host_dma_read_desc_ram_addr,
  input  wire dma_len_t       host_dma_read_desc_len,
  input  wire host_tag_t      host_dma_read_desc_tag,
  input  wire                 host_dma_read_desc_valid,
  output logic                host_dma_read_desc_ready,

  output host_tag_t           host_dma_read_desc_status_tag,
  output logic                host_dma_read_desc_status_valid,

  // Core read requests
  input  wire ctrl_word_t     cores_ctrl_s_tdata,
  input  wire core_id_t       cores_ctrl_s_tuser,
  input  wire                 cores_ctrl_s_tvalid,
  output logic                cores_ctrl_s_tready,

  // PCIe DMA
  output pcie_addr_t          pcie_dma_read_desc_pcie_addr,
  output scratch_addr_t       pcie_dma_read_desc_ram_addr,
  output dma_len_t            pcie_dma_read_desc_len,
  output slot_t               pcie_dma_read_desc_tag,
  output logic                pcie_dma_read_desc_valid,
  input  wire                 pcie_dma_read_desc_ready,

  input  wire slot_t          pcie_dma_read_desc_status_tag,
  input  wire                 pcie_dma_read_desc_status_valid,

  // Data mover
  output scratch_addr_t       readout_desc_ram_addr,
  output dma_len_t            readout_desc_len,
  output slot_t               readout_desc_tag,
  output core_dest_t          readout_desc_dest,
  output core_addr_t          readout_desc_user,
  output logic                readout_desc_valid,
  input  wire                 readout_desc_ready,

  input  wire slot_t          readout_desc_status_tag,
  input  wire                 readout_desc_status_valid
);

  localparam int PCIE_DESC_BITS = $bits(pcie_addr_t) + $bits(dma_len_t) + $bits(slot_t);
  localparam int READOUT_DESC_BITS = $bits(dma_len_t) + $bits(slot_t) +
                                     $bits(core_dest_t) + $bits(core_addr_t);

  pcie_addr_t desc_pcie_addr;
  dma_len_t   desc_len;
  slot_t      desc_slot;
  logic       desc_push;

  dma_len_t   rd_len;
  slot_t      rd_slot;
  core_dest_t rd_dest;
  core_addr_t rd_core_addr;
  logic       rd_push;

  logic [PCIE_DESC_BITS-1:0]    pcie_desc_dout;
  logic [READOUT_DESC_BITS-1:0] readout_desc_dout;

  slot_alloc_if  alloc_bus ();
  slot_lookup_if lookup_bus ();

  req_intake req_intake_inst (
    .pcie_clk       (pcie_clk),
    .pcie_rst       (pcie_rst),
    .host_pcie_addr (host_dma_read_desc_pcie_addr),
    .host_ram_addr  (host_dma_read_desc_ram_addr),
    .host_len       (host_dma_read_desc_len),
    .host_tag       (host_dma_read_desc_tag),
    .host_valid     (host_dma_read_desc_valid),
    .host_ready     (host_dma_read_desc_ready),
    .ctrl_data      (cores_ctrl_s_tdata),
    .ctrl_core      (cores_ctrl_s_tuser),
    .ctrl_valid     (cores_ctrl_s_tvalid),
    .ctrl_ready     (cores_ctrl_s_tready),
    .alloc          (alloc_bus),
    .desc_pcie_addr (desc_pcie_addr),
    .desc_len       (desc_len),
    .desc_slot      (desc_slot),
    .desc_push      (desc_push)
  );

  slot_table slot_table_inst (
    .pcie_clk (pcie_clk),
    .pcie_rst (pcie_rst),
    .alloc    (alloc_bus),
    .lookup   (lookup_bus)
  );

  completion_stage completion_stage_inst (
    .pcie_clk             (pcie_clk),
    .pcie_rst             (pcie_rst),
    .pcie_status_slot     (pcie_dma_read_desc_status_tag),
    .pcie_status_valid    (pcie_dma_read_desc_status_valid),
    .readout_status_slot  (readout_desc_status_tag),
    .readout_status_valid (readout_desc_status_valid),
    .lookup               (lookup_bus),
    .rd_len               (rd_len),
    .rd_slot              (rd_slot),
    .rd_dest              (rd_dest),
    .rd_core_addr         (rd_core_addr),
    .rd_push              (rd_push),
    .host_status_tag      (host_dma_read_desc_status_tag),
    .host_status_valid    (host_dma_read_desc_status_valid)
  );

  // Both queues hold at most one entry per slot
  desc_fifo #(
    .WIDTH (PCIE_DESC_BITS),
    .DEPTH (`RD_SLOT_COUNT)
  ) pcie_desc_fifo (
    .pcie_clk   (pcie_clk),
    .pcie_rst   (pcie_rst),
    .din        ({desc_pcie_addr, desc_len, desc_slot}),
    .din_valid  (desc_push),
    .dout       (pcie_desc_dout),
    .dout_valid (pcie_dma_read_desc_valid),
    .dout_ready (pcie_dma_read_desc_ready)
  );

  desc_fifo #(
    .WIDTH (READOUT_DESC_BITS),
    .DEPTH (`RD_SLOT_COUNT)
  ) readout_desc_fifo (
    .pcie_clk   (pcie_clk),
    .pcie_rst   (pcie_rst),
    .din        ({rd_len, rd_slot, rd_dest, rd_core_addr}),
    .din_valid  (rd_push),
    .dout       (readout_desc_dout),
    .dout_valid (readout_desc_valid),
    .dout_ready (readout_desc_ready)
  );

  assign {pcie_dma_read_desc_pcie_addr, pcie_dma_read_desc_len,
          pcie_dma_read_desc_tag} = pcie_desc_dout;
  assign {readout_desc_len, readout_desc_tag, readout_desc_dest,
          readout_desc_user} = readout_desc_dout;

  // Each slot owns a 2 KB window of the scratchpad
  assign pcie_dma_read_desc_ram_addr = {pcie_dma_read_desc_tag, {`RD_SLOT_SPAN_BITS{1'b0}}};
  assign readout_desc_ram_addr       = {readout_desc_tag, {`RD_SLOT_SPAN_BITS{1'b0}}};

endmodule

`default_nettype wire

// File: design/req_intake.sv
`timescale 1ns/100ps
`default_nettype none

`include "rd_cfg.svh"

module req_intake import rd_pkg::*; (
  input  wire                pcie_clk,
  input  wire                pcie_rst,

  input  wire pcie_addr_t    host_pcie_addr,
  input  wire host_ram_addr_t host_ram_addr,
  input  wire dma_len_t      host_len,
  input  wire host_tag_t     host_tag,
  input  wire                host_valid,
  output logic               host_ready,

  input  wire ctrl_word_t    ctrl_data,
  input  wire core_id_t      ctrl_core,
  input  wire                ctrl_valid,
  output logic               ctrl_ready,

  slot_alloc_if.intake       alloc,

  output pcie_addr_t         desc_pcie_addr,
  output dma_len_t           desc_len,
  output slot_t              desc_slot,
  output logic               desc_push
);

  localparam int DEST_LOW_BITS = `RD_CORE_DEST_BITS - `RD_CORE_ID_BITS;

  logic       host_fire;
  logic       core_fire;
  pcie_addr_t sel_pcie_addr;

  // Host wins, a pending host request blocks the core port
  assign host_ready = alloc.any_free;
  assign ctrl_ready = alloc.any_free && !host_valid;

  assign host_fire = host_valid && host_ready;
  assign core_fire = ctrl_valid && ctrl_ready;

  assign alloc.alloc = host_fire || core_fire;

  always_comb begin
    if (host_fire) begin
      sel_pcie_addr         = host_pcie_addr;
      alloc.entry_len       = host_len;
      alloc.entry_core_addr = host_ram_addr[`RD_CORE_ADDR_BITS-1:0];
      alloc.entry_dest      = {host_ram_addr[`RD_CORE_ADDR_BITS +: `RD_CORE_ID_BITS],
                               {DEST_LOW_BITS{1'b0}}};
      alloc.entry_host_tag  = host_tag;
    end else begin
      sel_pcie_addr         = ctrl_data[`RD_CTRL_PCIE_ADDR_LSB +: `RD_PCIE_ADDR_BITS];
      alloc.entry_len       = ctrl_data[`RD_CTRL_LEN_LSB +: `RD_LEN_BITS];
      alloc.entry_core_addr = ctrl_data[`RD_CTRL_CORE_ADDR_LSB +: `RD_CORE_ADDR_BITS];
      alloc.entry_dest      = {ctrl_core, ctrl_data[`RD_CTRL_DEST_LSB +: DEST_LOW_BITS]};
      // Core requests never report status
      alloc.entry_host_tag  = '0;
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      desc_push <= 1'b0;
    end else begin
      desc_push <= alloc.alloc;
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (alloc.alloc) begin
      desc_pcie_addr <= sel_pcie_addr;
      desc_len       <= alloc.entry_len;
      desc_slot      <= alloc.free_slot;
    end
  end

endmodule

`default_nettype wire

// File: design/slot_table.sv
`timescale 1ns/100ps
`default_nettype none

`include "rd_cfg.svh"

module slot_table import rd_pkg::*; (
  input  wire          pcie_clk,
  input  wire          pcie_rst,

  slot_alloc_if.store  alloc,
  slot_lookup_if.store lookup
);

  logic [`RD_SLOT_COUNT-1:0] free_mask;
  logic [`RD_SLOT_COUNT-1:0] alloc_onehot;
  logic [`RD_SLOT_COUNT-1:0] release_onehot;
  slot_t                     pick;

  dma_len_t   len_mem       [`RD_SLOT_COUNT];
  core_addr_t core_addr_mem [`RD_SLOT_COUNT];
  core_dest_t dest_mem      [`RD_SLOT_COUNT];
  host_tag_t  host_tag_mem  [`RD_SLOT_COUNT];

  // Lowest free slot, scanning down so the lowest index wins
  always_comb begin
    pick = '0;
    for (int i = `RD_SLOT_COUNT - 1; i >= 0; i--) begin
      if (free_mask[i]) begin
        pick = slot_t'(i);
      end
    end
  end

  assign alloc.free_slot = pick;
  assign alloc.any_free  = |free_mask;

  assign alloc_onehot   = alloc.alloc ? (`RD_SLOT_COUNT'(1) << pick) : '0;
  assign release_onehot = lookup.release_valid ?
                          (`RD_SLOT_COUNT'(1) << lookup.release_slot) : '0;

  // Alloc and release never name the same slot
  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      free_mask <= '1;
    end else begin
      free_mask <= (free_mask & ~alloc_onehot) | release_onehot;
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (alloc.alloc) begin
      len_mem[pick]       <= alloc.entry_len;
      core_addr_mem[pick] <= alloc.entry_core_addr;
      dest_mem[pick]      <= alloc.entry_dest;
      host_tag_mem[pick]  <= alloc.entry_host_tag;
    end
  end

  // PCIe completion read port
  assign lookup.entry_len       = len_mem[lookup.lookup_slot];
  assign lookup.entry_core_addr = core_addr_mem[lookup.lookup_slot];
  assign lookup.entry_dest      = dest_mem[lookup.lookup_slot];
  assign lookup.entry_host_tag  = host_tag_mem[lookup.lookup_slot];

  // Readout completion read port
  assign lookup.release_host_tag = host_tag_mem[lookup.release_slot];

endmodule

`default_nettype wire

// File: dv/tb_pcie_cont_read.sv
`timescale 1ns/100ps
`default_nettype none

module tb_pcie_cont_read import rd_pkg::*; ();

  localparam int SLOTS        = 16;
  localparam int HOST_REQS    = 12;
  localparam int CORE_REQS    = 12;
  localparam int MIXED_ROUNDS = 30;
  localparam int FILL_REQS    = 16;
  localparam int HOLD_CYCLES  = 40;
  // Mixed rounds carry up to two requests and the fill phase ends with a pair
  localparam int REQ_TOTAL = HOST_REQS + CORE_REQS + 2 * MIXED_ROUNDS + FILL_REQS + 2;

  typedef struct packed {
    pcie_addr_t pcie_addr;
    dma_len_t   len;
    core_addr_t core_addr;
    core_dest_t dest;
    host_tag_t  host_tag;
  } entry_t;

  typedef struct packed {
    pcie_addr_t    pcie_addr;
    scratch_addr_t ram_addr;
    dma_len_t      len;
    slot_t         tag;
  } pcie_desc_t;

  typedef struct packed {
    scratch_addr_t ram_addr;
    dma_len_t      len;
    slot_t         tag;
    core_dest_t    dest;
    core_addr_t    user;
  } readout_desc_t;

  logic           pcie_clk = 1'b0;
  logic           pcie_rst = 1'b1;
  pcie_addr_t     host_dma_read_desc_pcie_addr = '0;
  host_ram_addr_t host_dma_read_desc_ram_addr = '0;
  dma_len_t       host_dma_read_desc_len = '0;
  host_tag_t      host_dma_read_desc_tag = '0;
  logic           host_dma_read_desc_valid = 1'b0;
  logic           host_dma_read_desc_ready;
  host_tag_t      host_dma_read_desc_status_tag;
  logic           host_dma_read_desc_status_valid;
  ctrl_word_t     cores_ctrl_s_tdata = '0;
  core_id_t       cores_ctrl_s_tuser = '0;
  logic           cores_ctrl_s_tvalid = 1'b0;
  logic           cores_ctrl_s_tready;
  pcie_addr_t     pcie_dma_read_desc_pcie_addr;
  scratch_addr_t  pcie_dma_read_desc_ram_addr;
  dma_len_t       pcie_dma_read_desc_len;
  slot_t          pcie_dma_read_desc_tag;
  logic           pcie_dma_read_desc_valid;
  logic           pcie_dma_read_desc_ready = 1'b0;
  slot_t          pcie_dma_read_desc_status_tag = '0;
  logic           pcie_dma_read_desc_status_valid = 1'b0;
  scratch_addr_t  readout_desc_ram_addr;
  dma_len_t       readout_desc_len;
  slot_t          readout_desc_tag;
  core_dest_t     readout_desc_dest;
  core_addr_t     readout_desc_user;
  logic           readout_desc_valid;
  logic           readout_desc_ready = 1'b0;
  slot_t          readout_desc_status_tag = '0;
  logic           readout_desc_status_valid = 1'b0;

  // Model state
  entry_t            model_entry [SLOTS];
  logic [SLOTS-1:0]  model_free = '1;
  pcie_desc_t        exp_pcie_q[$];
  readout_desc_t     exp_readout_q[$];
  slot_t             pcie_pending[$];
  slot_t             readout_pending[$];
  logic              release_pend = 1'b0;
  slot_t             release_slot = '0;

  logic [31:0] stim_rng    = 32'd73;
  logic [31:0] pcie_rng    = 32'd73 + 32'd1;
  logic [31:0] readout_rng = 32'd73 + 32'd2;
  logic        pcie_hold   = 1'b0;
  string       test_name   = "reset";

  pcie_cont_read pcie_cont_read_inst (.*);

  always #2 pcie_clk = ~pcie_clk;

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic slot_t lowest_free(input logic [SLOTS-1:0] mask);
    slot_t s;
    logic  found;
    s = '0;
    found = 1'b0;
    for (int i = 0; i < SLOTS; i++) begin
      if (mask[i] && !found) begin
        s = slot_t'(i);
        found = 1'b1;
      end
    end
    return s;
  endfunction

  function automatic scratch_addr_t slot_ram_addr(input slot_t slot);
    return scratch_addr_t'(slot) * scratch_addr_t'(2048);
  endfunction

  // Bookkeeping a request should leave in its slot
  function automatic entry_t expect_entry(input logic is_host, input pcie_addr_t h_addr,
                                          input host_ram_addr_t h_ram, input dma_len_t h_len,
                                          input host_tag_t h_tag, input ctrl_word_t c_word,
                                          input core_id_t c_core);
    entry_t e;
    if (is_host) begin
      e.pcie_addr = h_addr;
      e.len       = h_len;
      e.core_addr = h_ram[15:0];
      e.dest      = {h_ram[19:16], 5'b00000};
      e.host_tag  = h_tag;
    end else begin
      e.pcie_addr = c_word[127:64];
      e.len       = c_word[15:0];
      e.core_addr = c_word[47:32];
      e.dest      = {c_core, c_word[20:16]};
      e.host_tag  = '0;
    end
    return e;
  endfunction

  task automatic abort_run();
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic report_problem(input string what);
    $display("%s: %s", test_name, what);
    abort_run();
  endtask

  task automatic value_error(input string field, input logic [63:0] exp, input logic [63:0] act);
    $display("ERR %s %s expected 0x%0h actual 0x%0h", test_name, field, exp, act);
    abort_run();
  endtask

  task automatic check_ready(input string port, input logic exp, input logic act);
    if (act !== exp) value_error(port, 64'(exp), 64'(act));
  endtask

  task automatic check_pcie_desc(input pcie_desc_t exp, input pcie_desc_t act);
    if (act.pcie_addr !== exp.pcie_addr) value_error("pcie addr", exp.pcie_addr, act.pcie_addr);
    if (act.ram_addr !== exp.ram_addr)
      value_error("pcie ram addr", 64'(exp.ram_addr), 64'(act.ram_addr));
    if (act.len !== exp.len) value_error("pcie len", 64'(exp.len), 64'(act.len));
    if (act.tag !== exp.tag) value_error("pcie tag", 64'(exp.tag), 64'(act.tag));
  endtask

  task automatic check_readout_desc(input readout_desc_t exp, input readout_desc_t act);
    if (act.ram_addr !== exp.ram_addr)
      value_error("readout ram addr", 64'(exp.ram_addr), 64'(act.ram_addr));
    if (act.len !== exp.len) value_error("readout len", 64'(exp.len), 64'(act.len));
    if (act.tag !== exp.tag) value_error("readout tag", 64'(exp.tag), 64'(act.tag));
    if (act.dest !== exp.dest) value_error("readout dest", 64'(exp.dest), 64'(act.dest));
    if (act.user !== exp.user) value_error("readout user", 64'(exp.user), 64'(act.user));
  endtask

  task automatic check_host_status(input logic exp_valid, input host_tag_t exp_tag,
                                   input logic act_valid, input host_tag_t act_tag);
    if (act_valid !== exp_valid)
      value_error("status valid", 64'(exp_valid), 64'(act_valid));
    else if (exp_valid && act_tag !== exp_tag)
      value_error("status tag", 64'(exp_tag), 64'(act_tag));
  endtask

  // Handshakes are sampled at the rising edge, before any register updates
  always @(posedge pcie_clk) begin : compare
    entry_t        e;
    slot_t         s;
    pcie_desc_t    pd;
    readout_desc_t rd;
    if (!pcie_rst) begin
      check_ready("host ready", model_free != '0, host_dma_read_desc_ready);
      check_ready("core ready", (model_free != '0) && !host_dma_read_desc_valid,
                  cores_ctrl_s_tready);
      check_host_status(release_pend && (model_entry[release_slot].host_tag != '0),
                        model_entry[release_slot].host_tag,
                        host_dma_read_desc_status_valid, host_dma_read_desc_status_tag);
      if (pcie_dma_read_desc_valid) begin
        if (exp_pcie_q.size() == 0) report_problem("PCIe descriptor with none outstanding");
        pd.pcie_addr = pcie_dma_read_desc_pcie_addr;
        pd.ram_addr  = pcie_dma_read_desc_ram_addr;
        pd.len       = pcie_dma_read_desc_len;
        pd.tag       = pcie_dma_read_desc_tag;
        check_pcie_desc(exp_pcie_q[0], pd);
        if (pcie_dma_read_desc_ready) begin
          void'(exp_pcie_q.pop_front());
          pcie_pending.push_back(pd.tag);
        end
      end
      if (readout_desc_valid) begin
        if (exp_readout_q.size() == 0) report_problem("readout descriptor with none outstanding");
        rd.ram_addr = readout_desc_ram_addr;
        rd.len      = readout_desc_len;
        rd.tag      = readout_desc_tag;
        rd.dest     = readout_desc_dest;
        rd.user     = readout_desc_user;
        check_readout_desc(exp_readout_q[0], rd);
        if (readout_desc_ready) begin
          void'(exp_readout_q.pop_front());
          readout_pending.push_back(rd.tag);
        end
      end
      if (host_dma_read_desc_valid && host_dma_read_desc_ready) begin
        e = expect_entry(1'b1, host_dma_read_desc_pcie_addr, host_dma_read_desc_ram_addr,
                         host_dma_read_desc_len, host_dma_read_desc_tag, '0, '0);
      end else begin
        e = expect_entry(1'b0, '0, '0, '0, '0, cores_ctrl_s_tdata, cores_ctrl_s_tuser);
      end
      if ((host_dma_read_desc_valid && host_dma_read_desc_ready) ||
          (cores_ctrl_s_tvalid && cores_ctrl_s_tready)) begin
        s = lowest_free(model_free);
        model_entry[s] = e;
        model_free[s] = 1'b0;
        pd.pcie_addr = e.pcie_addr;
        pd.ram_addr  = slot_ram_addr(s);
        pd.len       = e.len;
        pd.tag       = s;
        exp_pcie_q.push_back(pd);
      end
      if (pcie_dma_read_desc_status_valid) begin
        s = pcie_dma_read_desc_status_tag;
        rd.ram_addr = slot_ram_addr(s);
        rd.len      = model_entry[s].len;
        rd.tag      = s;
        rd.dest     = model_entry[s].dest;
        rd.user     = model_entry[s].core_addr;
        exp_readout_q.push_back(rd);
      end
      // The slot comes back one cycle after its readout status
      if (release_pend) model_free[release_slot] = 1'b1;
      release_pend = readout_desc_status_valid;
      release_slot = readout_desc_status_tag;
    end
  end

  always @(negedge pcie_clk) begin : pcie_dma_model
    int idx;
    pcie_rng = lcg_step(pcie_rng);
    pcie_dma_read_desc_ready = !pcie_rst && !pcie_hold && (pcie_rng[17:16] != 2'd0);
    pcie_rng = lcg_step(pcie_rng);
    if (!pcie_rst && pcie_pending.size() > 0 && pcie_rng[18:16] < 3'd3) begin
      idx = int'(pcie_rng[30:20]) % pcie_pending.size();
      pcie_dma_read_desc_status_tag = pcie_pending[idx];
      pcie_dma_read_desc_status_valid = 1'b1;
      pcie_pending.delete(idx);
    end else begin
      pcie_dma_read_desc_status_valid = 1'b0;
    end
  end

  always @(negedge pcie_clk) begin : data_mover_model
    int idx;
    readout_rng = lcg_step(readout_rng);
    readout_desc_ready = !pcie_rst && (readout_rng[17:16] != 2'd0);
    readout_rng = lcg_step(readout_rng);
    if (!pcie_rst && readout_pending.size() > 0 && readout_rng[18:16] < 3'd3) begin
      idx = int'(readout_rng[30:20]) % readout_pending.size();
      readout_desc_status_tag = readout_pending[idx];
      readout_desc_status_valid = 1'b1;
      readout_pending.delete(idx);
    end else begin
      readout_desc_status_valid = 1'b0;
    end
  end

  task automatic next_rand(output logic [31:0] r);
    stim_rng = lcg_step(stim_rng);
    r = stim_rng;
  endtask

  // Presents a host request, a core request or both, and waits for acceptance
  task automatic drive_request(input logic use_host, input logic use_core);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic        host_done;
    logic        core_done;
    host_done = !use_host;
    core_done = !use_core;
    @(negedge pcie_clk);
    if (use_host) begin
      next_rand(r0);
      next_rand(r1);
      next_rand(r2);
      next_rand(r3);
      host_dma_read_desc_pcie_addr = {r0, r1};
      host_dma_read_desc_ram_addr  = r2;
      host_dma_read_desc_len       = r3[31:16];
      next_rand(r0);
      host_dma_read_desc_tag = (r0[17:16] == 2'd0) ? '0 : lcg_step(r0);
      host_dma_read_desc_valid = 1'b1;
    end
    if (use_core) begin
      next_rand(r0);
      next_rand(r1);
      next_rand(r2);
      next_rand(r3);
      cores_ctrl_s_tdata  = {r0, r1, r2, r3};
      cores_ctrl_s_tuser  = r0[19:16];
      cores_ctrl_s_tvalid = 1'b1;
    end
    while (!(host_done && core_done)) begin
      @(posedge pcie_clk);
      if (host_dma_read_desc_valid && host_dma_read_desc_ready) host_done = 1'b1;
      if (cores_ctrl_s_tvalid && cores_ctrl_s_tready) core_done = 1'b1;
      @(negedge pcie_clk);
      if (host_done) host_dma_read_desc_valid = 1'b0;
      if (core_done) cores_ctrl_s_tvalid = 1'b0;
    end
  endtask

  // Mode 0 host, 1 core, 2 both at once, 3 random choice of those
  task automatic issue_requests(input int count, input int mode);
    int kind;
    for (int n = 0; n < count; n++) begin
      kind = mode;
      if (mode == 3) begin
        stim_rng = lcg_step(stim_rng);
        kind = int'(stim_rng[17:16]) % 3;
      end
      drive_request(kind != 1, kind != 0);
    end
  endtask

  task automatic wait_idle();
    while (model_free != '1 || exp_pcie_q.size() != 0 || exp_readout_q.size() != 0 ||
           pcie_pending.size() != 0 || readout_pending.size() != 0 || release_pend) begin
      @(negedge pcie_clk);
    end
  endtask

  initial begin : stimulus
    repeat (16) @(posedge pcie_clk);
    @(negedge pcie_clk);
    pcie_rst = 1'b0;
    test_name = "host_req";
    issue_requests(HOST_REQS, 0);
    wait_idle();
    test_name = "core_req";
    issue_requests(CORE_REQS, 1);
    wait_idle();
    test_name = "mixed";
    issue_requests(MIXED_ROUNDS, 3);
    wait_idle();
    // All slots in flight while the PCIe side stalls
    test_name = "fill";
    pcie_hold = 1'b1;
    issue_requests(FILL_REQS / 2, 0);
    issue_requests(FILL_REQS / 2, 1);
    check_ready("host ready", 1'b0, host_dma_read_desc_ready);
    check_ready("core ready", 1'b0, cores_ctrl_s_tready);
    fork
      begin
        repeat (HOLD_CYCLES) @(negedge pcie_clk);
        pcie_hold = 1'b0;
      end
    join_none
    issue_requests(1, 2);
    wait_idle();
    repeat (20) @(negedge pcie_clk);
    $display(">>> PASS");
    $finish;
  end

  initial begin : watchdog
    repeat (REQ_TOTAL * 200) @(posedge pcie_clk);
    $display("Timeout: run did not finish within %0d cycles", REQ_TOTAL * 200);
    abort_run();
  end

endmodule

`default_nettype wire

// File: pcie_cont_read.f
+incdir+common
common/rd_pkg.sv
common/slot_alloc_if.sv
common/slot_lookup_if.sv
design/desc_fifo.sv
design/slot_table.sv
design/req_intake.sv
design/completion_stage.sv
design/pcie_cont_read.sv
dv/tb_pcie_cont_read.sv
